// ==== bandFilterBank.sv ====
`timescale 1ns/1ns

module bandFilterBank (
	input  logic aud_clk,
	input  logic rstN,
	input  vizPkg::sample_t sampleIn,
	input  logic sampleStrobe,
	output vizPkg::sample_t bandSamples [vizPkg::NUM_BANDS],
	output logic bandValid
);
	import vizPkg::*;

	// low-pass states carry two guard bits
	logic signed [17:0] lp1;
	logic signed [17:0] lp2;
	logic signed [17:0] lp3;

	logic signed [17:0] sampleWide;
	logic signed [17:0] lp1Next;
	logic signed [17:0] lp2Next;
	logic signed [17:0] lp3Next;
	logic signed [17:0] bandWide [NUM_BANDS];

	// clamp to the signed 16 bit range
	function automatic sample_t satSample(input logic signed [17:0] v);
		if (v > 18'sd32767) begin
			return 16'sh7fff;
		end
		if (v < -18'sd32768) begin
			return 16'sh8000;
		end
		return sample_t'(v[15:0]);
	endfunction

	always_comb begin
		sampleWide = 18'(sampleIn);
		// each stage follows the freshly updated stage before it
		lp1Next = lp1 + ((sampleWide - lp1) >>> LP_SHIFT1);
		lp2Next = lp2 + ((lp1Next - lp2) >>> LP_SHIFT2);
		lp3Next = lp3 + ((lp2Next - lp3) >>> LP_SHIFT3);
		// band 0 lowest, band 3 highest
		bandWide[0] = lp3Next;
		bandWide[1] = lp2Next - lp3Next;
		bandWide[2] = lp1Next - lp2Next;
		bandWide[3] = sampleWide - lp1Next;
	end

	always_ff @(posedge aud_clk or negedge rstN) begin
		if (!rstN) begin
			lp1 <= '0;
			lp2 <= '0;
			lp3 <= '0;
			bandValid <= 1'b0;
		end else begin
			bandValid <= sampleStrobe;
			if (sampleStrobe) begin
				lp1 <= lp1Next;
				lp2 <= lp2Next;
				lp3 <= lp3Next;
			end
		end
	end

	// band samples latch with each strobe
	always_ff @(posedge aud_clk) begin
		if (sampleStrobe) begin
			for (int b = 0; b < NUM_BANDS; b++) begin
				bandSamples[b] <= satSample(bandWide[b]);
			end
		end
	end

endmodule

// ==== bandMeter.sv ====
`timescale 1ns/1ns

module bandMeter (
	input  logic aud_clk,
	input  logic rstN,
	input  vizPkg::sample_t bandSamples [vizPkg::NUM_BANDS],
	input  logic bandValid,
	input  logic [vizPkg::NUM_BANDS-1:0] bandEn,
	output vizPkg::meterBus_t meters
);
	import vizPkg::*;

	mag_t env [NUM_BANDS];
	mag_t peak [NUM_BANDS];
	mag_t magVal [NUM_BANDS];
	mag_t envNext [NUM_BANDS];
	mag_t peakNext [NUM_BANDS];

	// cells = magnitude / 4096, capped at the top cell
	function automatic level_t toLevel(input mag_t m);
		mag_t shifted;
		shifted = m >> LEVEL_SHIFT;
		if (shifted > MAX_LEVEL) begin
			return level_t'(MAX_LEVEL);
		end
		return level_t'(shifted);
	endfunction

	always_comb begin
		logic signed [16:0] absWide;
		logic signed [16:0] envDiff;
		for (int b = 0; b < NUM_BANDS; b++) begin
			// -32768 rectifies to 32768, clamp it back
			absWide = bandSamples[b][15] ? -17'(bandSamples[b]) : 17'(bandSamples[b]);
			magVal[b] = (absWide > 17'sd32767) ? 16'h7fff : mag_t'(absWide[15:0]);
			envDiff = $signed({1'b0, magVal[b]}) - $signed({1'b0, env[b]});
			envNext[b] = env[b] + mag_t'(envDiff >>> ENV_SHIFT);
			// peak jumps up, bleeds off slowly
			if (magVal[b] > peak[b]) begin
				peakNext[b] = magVal[b];
			end else begin
				peakNext[b] = peak[b] - (peak[b] >> PEAK_DECAY_SHIFT);
			end
			if (!bandEn[b]) begin
				envNext[b] = '0;
				peakNext[b] = '0;
			end
		end
	end

	always_ff @(posedge aud_clk or negedge rstN) begin
		if (!rstN) begin
			for (int b = 0; b < NUM_BANDS; b++) begin
				env[b] <= '0;
				peak[b] <= '0;
			end
			meters <= '0;
		end else if (bandValid) begin
			for (int b = 0; b < NUM_BANDS; b++) begin
				env[b] <= envNext[b];
				peak[b] <= peakNext[b];
				meters[b].barLevel <= toLevel(envNext[b]);
				meters[b].peakLevel <= toLevel(peakNext[b]);
			end
		end
	end

endmodule

// ==== barRenderer.sv ====
`timescale 1ns/1ns

module barRenderer (
	input  vizPkg::coordX_t pixelX,
	input  vizPkg::coordY_t pixelY,
	input  vizPkg::meterBus_t meters,
	output logic markerHit,
	output logic barHit,
	output logic gapHit
);
	import vizPkg::*;

	logic [$bits(coordX_t)-COL_SHIFT-1:0] colIdx;
	logic [COL_SHIFT-1:0] colOffset;
	logic inColumns;
	level_t cellRow;
	bandLevels_t selLevels;

	always_comb begin
		colIdx = pixelX[$bits(coordX_t)-1:COL_SHIFT];
		colOffset = pixelX[COL_SHIFT-1:0];
		// columns end at x 512
		inColumns = colIdx < NUM_BANDS;
		selLevels = meters[colIdx[BAND_IDX_W-1:0]];
		// row 0 is the bottom cell
		cellRow = level_t'(MAX_LEVEL - 1) - level_t'(pixelY >> ROW_SHIFT);
	end

	// left edge of each column is a gap
	assign gapHit = !inColumns || (colOffset < GAP_WIDTH);

	assign barHit = inColumns && (cellRow < selLevels.barLevel);

	// marker sits in the cell just under the peak level
	assign markerHit = inColumns && (selLevels.peakLevel != '0)
		&& (cellRow == selLevels.peakLevel - level_t'(1));

endmodule

// ==== pixelCompositor.sv ====
`timescale 1ns/1ns

module pixelCompositor (
	input  logic aud_clk,
	input  logic rstN,
	input  logic markerHit,
	input  logic barHit,
	input  logic gapHit,
	input  vizPkg::vizCfg_t cfg,
	output vizPkg::rgb_t rgbOut
);
	import vizPkg::*;

	// bit order sets priority, msb wins
	logic [2:0] layerVec;
	logic [2:0] layerOH;

	assign layerVec = {gapHit, markerHit, barHit};

	always_comb begin
		layerOH = '0;
		for (int i = 0; i < $bits(layerVec); i++) begin
			if (layerVec[i]) begin
				layerOH = 3'b001 << i;
			end
		end
	end

	always_ff @(posedge aud_clk or negedge rstN) begin
		if (!rstN) begin
			rgbOut <= '0;
		end else begin
			case (layerOH)
				3'b100: rgbOut <= cfg.bgColor;
				3'b010: rgbOut <= cfg.markerColor;
				3'b001: rgbOut <= cfg.barColor;
				// nothing hit
				default: rgbOut <= cfg.bgColor;
			endcase
		end
	end

endmodule

// ==== project.f ====
vizPkg.sv
bandFilterBank.sv
bandMeter.sv
vizConfig.sv
barRenderer.sv
pixelCompositor.sv
spectrumViz.sv
spectrumViz_properties.sv
tb_spectrumViz.sv

// ==== spectrumViz.sv ====
`timescale 1ns/1ns

module spectrumViz (
	input  logic aud_clk,
	input  logic rstN,
	input  vizPkg::sample_t sampleIn,
	input  logic sampleStrobe,
	input  logic cfgWrite,
	input  vizPkg::cfgAddr_t cfgAddr,
	input  logic [23:0] cfgData,
	input  vizPkg::coordX_t pixelX,
	input  vizPkg::coordY_t pixelY,
	output vizPkg::meterBus_t meterLevels,
	output vizPkg::rgb_t rgbOut
);
	import vizPkg::*;

	sample_t bandSamples [NUM_BANDS];
	logic bandValid;
	vizCfg_t cfg;
	logic markerHit;
	logic barHit;
	logic gapHit;

	// audio side
	bandFilterBank bandFilterBank_i (
		.aud_clk(aud_clk),
		.rstN(rstN),
		.sampleIn(sampleIn),
		.sampleStrobe(sampleStrobe),
		.bandSamples(bandSamples),
		.bandValid(bandValid)
	);

	bandMeter bandMeter_i (
		.aud_clk(aud_clk),
		.rstN(rstN),
		.bandSamples(bandSamples),
		.bandValid(bandValid),
		.bandEn(cfg.bandEn),
		.meters(meterLevels)
	);

	vizConfig vizConfig_i (
		.aud_clk(aud_clk),
		.rstN(rstN),
		.cfgWrite(cfgWrite),
		.cfgAddr(cfgAddr),
		.cfgData(cfgData),
		.cfg(cfg)
	);

	// pixel side
	barRenderer barRenderer_i (
		.pixelX(pixelX),
		.pixelY(pixelY),
		.meters(meterLevels),
		.markerHit(markerHit),
		.barHit(barHit),
		.gapHit(gapHit)
	);

	pixelCompositor pixelCompositor_i (
		.aud_clk(aud_clk),
		.rstN(rstN),
		.markerHit(markerHit),
		.barHit(barHit),
		.gapHit(gapHit),
		.cfg(cfg),
		.rgbOut(rgbOut)
	);

endmodule

// ==== spectrumViz_properties.sv ====
`timescale 1ns/1ns

module spectrumViz_properties (
	input logic aud_clk,
	input logic rstN,
	input logic sampleStrobe,
	input logic bandValid,
	input vizPkg::meterBus_t meterLevels,
	input vizPkg::rgb_t rgbOut
);
	import vizPkg::*;

	int unsigned assertFails = 0;

	// valid pulse only in the cycle after a strobe
	validAfterStrobe: assert property (@(posedge aud_clk) disable iff (!rstN)
		bandValid |-> $past(sampleStrobe))
		else begin
			$error("bandValid high without a strobe in the previous cycle");
			assertFails++;
		end

	strobeGivesValid: assert property (@(posedge aud_clk) disable iff (!rstN)
		sampleStrobe |=> bandValid)
		else begin
			$error("strobe not followed by bandValid");
			assertFails++;
		end

	for (genvar b = 0; b < NUM_BANDS; b++) begin : levelBounds
		levelInRange: assert property (@(posedge aud_clk) disable iff (!rstN)
			meterLevels[b].barLevel <= MAX_LEVEL && meterLevels[b].peakLevel <= MAX_LEVEL)
			else begin
				$error("band %0d level above the top cell", b);
				assertFails++;
			end
	end

	// colour output held at zero during reset
	rgbZeroInReset: assert property (@(posedge aud_clk) !rstN |-> rgbOut == '0)
		else begin
			$error("rgbOut not zero while reset is asserted");
			assertFails++;
		end

endmodule

// ==== tb_spectrumViz.sv ====
`timescale 1ns/1ns

module tb_spectrumViz;
	import vizPkg::*;

	localparam int clkPeriod = 100;
	localparam int driveDelay = 5;
	localparam int randStrobes = 40;
	localparam int loudStrobes = 8;
	localparam int quietStrobes = 24;
	localparam int burstStrobes = 12;
	localparam int maskStrobes = 16;
	// 5 offsets in each of 5 column slots plus x 1023, times 16 rows
	localparam int sweepLen = ((NUM_BANDS + 1) * 5 + 1) * 16;
	localparam int stimCycles = 16 + 4 * (randStrobes + loudStrobes + quietStrobes
		+ burstStrobes + maskStrobes) + 3 * sweepLen + 8;

	typedef struct packed {
		int unsigned due;
		meterBus_t levels;
	} meterExp_t;

	typedef struct packed {
		int unsigned due;
		coordX_t x;
		coordY_t y;
		rgb_t colour;
	} pixelExp_t;

	logic aud_clk;
	logic rstN;
	sample_t sampleIn;
	logic sampleStrobe;
	logic cfgWrite;
	cfgAddr_t cfgAddr;
	logic [23:0] cfgData;
	coordX_t pixelX;
	coordY_t pixelY;
	meterBus_t meterLevels;
	rgb_t rgbOut;

	int unsigned cycleCnt = 0;
	logic [31:0] lfsrState = 32'hc5f7dedf;
	meterExp_t meterQ [$];
	pixelExp_t pixelQ [$];

	// reference model state
	int lp1M = 0;
	int lp2M = 0;
	int lp3M = 0;
	int envM [NUM_BANDS] = '{default: 0};
	int peakM [NUM_BANDS] = '{default: 0};
	meterBus_t modelLevels = '0;
	vizCfg_t modelCfg = CFG_RESET;

	spectrumViz spectrumViz_i (
		.aud_clk(aud_clk),
		.rstN(rstN),
		.sampleIn(sampleIn),
		.sampleStrobe(sampleStrobe),
		.cfgWrite(cfgWrite),
		.cfgAddr(cfgAddr),
		.cfgData(cfgData),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.meterLevels(meterLevels),
		.rgbOut(rgbOut)
	);

	bind spectrumViz spectrumViz_properties propsCheck_i (
		.aud_clk(aud_clk),
		.rstN(rstN),
		.sampleStrobe(sampleStrobe),
		.bandValid(bandValid),
		.meterLevels(meterLevels),
		.rgbOut(rgbOut)
	);

	initial begin
		aud_clk = 1'b0;
		forever #(clkPeriod / 2) aud_clk = ~aud_clk;
	end

	always @(posedge aud_clk) begin
		cycleCnt <= cycleCnt + 1;
	end

	// Fibonacci taps 32 22 2 1, one step per bit
	function automatic logic [31:0] randBits(input int nBits);
		logic [31:0] result;
		logic fb;
		result = '0;
		for (int i = 0; i < nBits; i++) begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			result = {result[30:0], fb};
		end
		return result;
	endfunction

	function automatic int clampSample(input int v);
		if (v > 32767) begin
			return 32767;
		end
		if (v < -32768) begin
			return -32768;
		end
		return v;
	endfunction

	function automatic level_t toCells(input int m);
		int cells;
		cells = m >> LEVEL_SHIFT;
		if (cells > MAX_LEVEL) begin
			cells = MAX_LEVEL;
		end
		return level_t'(cells);
	endfunction

	// filter bank and meter for one strobe, returns the expected levels
	function automatic meterBus_t modelStrobe(input sample_t s);
		int x;
		int mag;
		int bands [NUM_BANDS];
		meterBus_t res;
		x = s;
		lp1M = lp1M + ((x - lp1M) >>> LP_SHIFT1);
		lp2M = lp2M + ((lp1M - lp2M) >>> LP_SHIFT2);
		lp3M = lp3M + ((lp2M - lp3M) >>> LP_SHIFT3);
		bands[0] = clampSample(lp3M);
		bands[1] = clampSample(lp2M - lp3M);
		bands[2] = clampSample(lp1M - lp2M);
		bands[3] = clampSample(x - lp1M);
		for (int b = 0; b < NUM_BANDS; b++) begin
			mag = (bands[b] < 0) ? -bands[b] : bands[b];
			if (mag > 32767) begin
				mag = 32767;
			end
			envM[b] = envM[b] + ((mag - envM[b]) >>> ENV_SHIFT);
			if (mag > peakM[b]) begin
				peakM[b] = mag;
			end else begin
				peakM[b] = peakM[b] - (peakM[b] >> PEAK_DECAY_SHIFT);
			end
			if (!modelCfg.bandEn[b]) begin
				envM[b] = 0;
				peakM[b] = 0;
			end
			res[b].barLevel = toCells(envM[b]);
			res[b].peakLevel = toCells(peakM[b]);
		end
		modelLevels = res;
		return res;
	endfunction

	function automatic rgb_t modelPixel(input coordX_t x, input coordY_t y);
		int col;
		int offs;
		int row;
		int peakCell;
		bandLevels_t lv;
		col = x >> COL_SHIFT;
		offs = x & ((1 << COL_SHIFT) - 1);
		if (x >= (NUM_BANDS << COL_SHIFT) || offs < GAP_WIDTH) begin
			return modelCfg.bgColor;
		end
		lv = modelLevels[col];
		row = (MAX_LEVEL - 1) - (y >> ROW_SHIFT);
		peakCell = lv.peakLevel;
		if (peakCell != 0 && row == peakCell - 1) begin
			return modelCfg.markerColor;
		end
		if (row < int'(lv.barLevel)) begin
			return modelCfg.barColor;
		end
		return modelCfg.bgColor;
	endfunction

	task automatic stopRun();
		$display("Verification failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic failRun(input string why);
		$display("ERROR at %0t ns: %s", $time, why);
		stopRun();
	endtask

	task automatic compareLevels(input int band, input bandLevels_t got, input bandLevels_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: band %0d got bar %0d peak %0d, expected bar %0d peak %0d",
				$time, band, got.barLevel, got.peakLevel, exp.barLevel, exp.peakLevel);
			stopRun();
		end
	endtask

	task automatic compareRgb(input coordX_t x, input coordY_t y, input rgb_t got, input rgb_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: pixel (%0d,%0d) got %06h, expected %06h",
				$time, x, y, got, exp);
			stopRun();
		end
	endtask

	// outputs are stable mid-cycle
	always @(negedge aud_clk) begin : compareResults
		meterExp_t me;
		pixelExp_t pe;
		while (meterQ.size() > 0 && meterQ[0].due == cycleCnt) begin
			me = meterQ.pop_front();
			for (int b = 0; b < NUM_BANDS; b++) begin
				compareLevels(b, meterLevels[b], me.levels[b]);
			end
		end
		while (pixelQ.size() > 0 && pixelQ[0].due == cycleCnt) begin
			pe = pixelQ.pop_front();
			compareRgb(pe.x, pe.y, rgbOut, pe.colour);
		end
	end

	always @(posedge aud_clk) begin
		if (spectrumViz_i.propsCheck_i.assertFails != 0) begin
			failRun("a bound assertion on the DUT failed");
		end
	end

	initial begin
		#(stimCycles * clkPeriod * 2);
		failRun("watchdog timeout, stimulus did not complete");
	end

	task automatic step();
		@(posedge aud_clk);
		#driveDelay;
	endtask

	// one strobe, then three idle cycles
	task automatic sendSample(input sample_t s);
		meterExp_t me;
		me.levels = modelStrobe(s);
		me.due = cycleCnt + 3;
		meterQ.push_back(me);
		sampleIn = s;
		sampleStrobe = 1'b1;
		step();
		sampleStrobe = 1'b0;
		repeat (3) step();
	endtask

	task automatic drivePixel(input coordX_t x, input coordY_t y);
		pixelExp_t pe;
		pe.due = cycleCnt + 1;
		pe.x = x;
		pe.y = y;
		pe.colour = modelPixel(x, y);
		pixelQ.push_back(pe);
		pixelX = x;
		pixelY = y;
		step();
	endtask

	// edges, gaps, column middles and the area past the last column
	task automatic sweepPixels();
		int offsets [5] = '{0, GAP_WIDTH - 1, GAP_WIDTH, 64, 127};
		for (int y = 0; y < 512; y += 32) begin
			for (int col = 0; col <= NUM_BANDS; col++) begin
				for (int k = 0; k < 5; k++) begin
					drivePixel(coordX_t'((col << COL_SHIFT) + offsets[k]), coordY_t'(y));
				end
			end
			drivePixel(coordX_t'(1023), coordY_t'(y));
		end
	endtask

	task automatic writeCfg(input cfgAddr_t addr, input logic [23:0] data);
		case (addr)
			ADDR_EN: modelCfg.bandEn = data[NUM_BANDS-1:0];
			ADDR_BAR: modelCfg.barColor = data;
			ADDR_MARKER: modelCfg.markerColor = data;
			default: modelCfg.bgColor = data;
		endcase
		cfgAddr = addr;
		cfgData = data;
		cfgWrite = 1'b1;
		step();
		cfgWrite = 1'b0;
	endtask

	initial begin
		rstN = 1'b1;
		sampleIn = '0;
		sampleStrobe = 1'b0;
		cfgWrite = 1'b0;
		cfgAddr = '0;
		cfgData = '0;
		pixelX = '0;
		pixelY = '0;
		#driveDelay;
		rstN = 1'b0;
		step();
		for (int b = 0; b < NUM_BANDS; b++) begin
			compareLevels(b, meterLevels[b], '0);
		end
		compareRgb(pixelX, pixelY, rgbOut, '0);
		step();
		rstN = 1'b1;

		// background everywhere while all levels are zero
		drivePixel(coordX_t'(0), coordY_t'(0));
		drivePixel(coordX_t'(200), coordY_t'(100));
		drivePixel(coordX_t'(700), coordY_t'(400));
		drivePixel(coordX_t'(100), coordY_t'(500));

		repeat (randStrobes) sendSample(sample_t'(randBits(16)));

		// loud step then silence
		repeat (loudStrobes) sendSample(16'sh7000);
		repeat (quietStrobes) sendSample(16'sh0000);

		repeat (burstStrobes) sendSample(sample_t'(randBits(16)));
		sweepPixels();

		writeCfg(ADDR_BAR, 24'hE03010);
		writeCfg(ADDR_MARKER, 24'h20F0F0);
		writeCfg(ADDR_BG, 24'h101010);
		sweepPixels();

		// bands 1 and 3 off
		writeCfg(ADDR_EN, 24'h000005);
		repeat (maskStrobes) sendSample(sample_t'(randBits(16)));
		compareLevels(1, meterLevels[1], '0);
		compareLevels(3, meterLevels[3], '0);
		sweepPixels();

		repeat (4) step();
		if (meterQ.size() == 0 && pixelQ.size() == 0
				&& spectrumViz_i.propsCheck_i.assertFails == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			failRun("expected results were left unchecked or an assertion failed");
		end
	end

endmodule

// ==== vizConfig.sv ====
`timescale 1ns/1ns

module vizConfig (
	input  logic aud_clk,
	input  logic rstN,
	input  logic cfgWrite,
	input  vizPkg::cfgAddr_t cfgAddr,
	input  logic [23:0] cfgData,
	output vizPkg::vizCfg_t cfg
);
	import vizPkg::*;

	// one field per address, colours take the full data word
	always_ff @(posedge aud_clk or negedge rstN) begin
		if (!rstN) begin
			cfg <= CFG_RESET;
		end else if (cfgWrite) begin
			case (cfgAddr)
				ADDR_EN: begin
					cfg.bandEn <= cfgData[NUM_BANDS-1:0];
				end
				ADDR_BAR: begin
					cfg.barColor <= cfgData;
				end
				ADDR_MARKER: begin
					cfg.markerColor <= cfgData;
				end
				ADDR_BG: begin
					cfg.bgColor <= cfgData;
				end
				default: begin
					cfg <= cfg;
				end
			endcase
		end
	end

endmodule

// ==== vizPkg.sv ====
package vizPkg;

	// band count and bar height range
	localparam int NUM_BANDS = 4;
	localparam int BAND_IDX_W = $clog2(NUM_BANDS);
	localparam int MAX_LEVEL = 8;

	// one-pole low-pass shifts, lp1 is the fastest
	localparam int LP_SHIFT1 = 2;
	localparam int LP_SHIFT2 = 4;
	localparam int LP_SHIFT3 = 6;

	// meter dynamics
	localparam int ENV_SHIFT = 3;
	localparam int PEAK_DECAY_SHIFT = 6;
	localparam int LEVEL_SHIFT = 12;

	// screen geometry, 128 pixel columns and 64 row cells
	localparam int COL_SHIFT = 7;
	localparam int GAP_WIDTH = 8;
	localparam int ROW_SHIFT = 6;

	typedef logic signed [15:0] sample_t;
	typedef logic [15:0] mag_t;
	typedef logic [3:0] level_t;
	typedef logic [9:0] coordX_t;
	typedef logic [8:0] coordY_t;
	typedef logic [1:0] cfgAddr_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	typedef struct packed {
		level_t barLevel;
		level_t peakLevel;
	} bandLevels_t;

	typedef bandLevels_t [NUM_BANDS-1:0] meterBus_t;

	typedef struct packed {
		logic [NUM_BANDS-1:0] bandEn;
		rgb_t barColor;
		rgb_t markerColor;
		rgb_t bgColor;
	} vizCfg_t;

	// register map
	localparam cfgAddr_t ADDR_EN = 2'd0;
	localparam cfgAddr_t ADDR_BAR = 2'd1;
	localparam cfgAddr_t ADDR_MARKER = 2'd2;
	localparam cfgAddr_t ADDR_BG = 2'd3;

	localparam vizCfg_t CFG_RESET = '{
		bandEn: '1,
		barColor: 24'h00C000,
		markerColor: 24'hFFFFFF,
		bgColor: 24'h000020
	};

endpackage
